//--- design/umio_pkg.sv
package umio_pkg;

	// Host side and link side data widths
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0]  reg_addr_t;

	// Opens every host write frame
	localparam byte_t SYNC_BYTE = 8'hA5;

	localparam reg_addr_t ADDR_CTRL = 8'h00;
	localparam reg_addr_t ADDR_TX   = 8'h01;

	// Start, 16 data bits MSB first, odd parity, stop
	localparam int FRAME_BITS = 19;

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_ADDR,
		DEC_DATA_HI,
		DEC_DATA_LO
	} dec_state_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

endpackage

//--- design/usb_decoder.sv
module usb_decoder import umio_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  byte_t     usb_d,
	input  logic      usb_valid,
	output reg_addr_t wr_addr,
	output word_t     wr_data,
	output logic      wr_en
);

	dec_state_t state;

	// Frame state and write strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= DEC_IDLE;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (usb_valid) begin
				case (state)
					DEC_IDLE: begin
						// Anything but the sync byte is dropped here
						if (usb_d == SYNC_BYTE) begin
							state <= DEC_ADDR;
						end
					end
					DEC_ADDR: begin
						state <= DEC_DATA_HI;
					end
					DEC_DATA_HI: begin
						state <= DEC_DATA_LO;
					end
					DEC_DATA_LO: begin
						wr_en <= 1'b1;
						state <= DEC_IDLE;
					end
					default: begin
						state <= DEC_IDLE;
					end
				endcase
			end
		end
	end

	// Address and data capture
	always_ff @(posedge clk) begin
		if (usb_valid) begin
			case (state)
				DEC_ADDR: begin
					wr_addr <= usb_d;
				end
				DEC_DATA_HI: begin
					wr_data[15:8] <= usb_d;
				end
				DEC_DATA_LO: begin
					wr_data[7:0] <= usb_d;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

//--- design/usb_ctrl_regs.sv
module usb_ctrl_regs import umio_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data,
	input  logic      wr_en,
	input  logic      tx_busy,
	output logic      com1_en,
	output logic      com2_en,
	output logic      dat_sel,
	output word_t     tx_word,
	output logic      tx_start
);

	logic tx_accept;

	// A launch only goes out while the master is idle
	assign tx_accept = wr_en && (wr_addr == ADDR_TX) && !tx_busy;

	// Control bits and launch strobe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			com1_en  <= 1'b1;
			com2_en  <= 1'b1;
			dat_sel  <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= tx_accept;
			if (wr_en && (wr_addr == ADDR_CTRL)) begin
				com1_en <= wr_data[0];
				com2_en <= wr_data[1];
				dat_sel <= wr_data[2];
			end
		end
	end

	// Transmit word
	always_ff @(posedge clk) begin
		if (tx_accept) begin
			tx_word <= wr_data;
		end
	end

endmodule

//--- design/hsi_master.sv
module hsi_master import umio_pkg::*; #(
	parameter int BIT_DIV = 8
) (
	input  logic  clk,
	input  logic  rst_n,
	input  word_t tx_word,
	input  logic  tx_start,
	input  logic  com1_en,
	input  logic  com2_en,
	output logic  com1,
	output logic  com2,
	output logic  tx_busy
);

	localparam int CNT_W = $clog2(BIT_DIV);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_DIV - 1);
	// Slot 0 is the start bit and data runs in slots 1 to 16
	localparam logic [4:0] LAST_DATA_SLOT = 5'(FRAME_BITS - 3);

	tx_state_t        state;
	logic [CNT_W-1:0] cnt;
	logic [4:0]       slot;
	word_t            shreg;
	logic             parity;
	logic             line;
	logic [1:0]       line_en;

	// Lines that are off for this frame rest at 1
	assign com1 = line | ~line_en[0];
	assign com2 = line | ~line_en[1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= TX_IDLE;
			cnt     <= '0;
			slot    <= '0;
			parity  <= 1'b1;
			line    <= 1'b1;
			line_en <= 2'b11;
			tx_busy <= 1'b0;
		end else if (state == TX_IDLE) begin
			if (tx_start) begin
				shreg   <= tx_word;
				line_en <= {com2_en, com1_en};
				line    <= 1'b0;
				parity  <= 1'b1;
				cnt     <= '0;
				slot    <= '0;
				tx_busy <= 1'b1;
				state   <= TX_START;
			end
		end else if (cnt != CNT_LAST) begin
			cnt <= cnt + 1'b1;
		end else begin
			// Next slot goes out at the end of each bit period
			cnt  <= '0;
			slot <= slot + 1'b1;
			case (state)
				TX_START, TX_DATA: begin
					if (state == TX_DATA && slot == LAST_DATA_SLOT) begin
						line  <= parity;
						state <= TX_PARITY;
					end else begin
						line   <= shreg[15];
						parity <= parity ^ shreg[15];
						shreg  <= {shreg[14:0], 1'b0};
						state  <= TX_DATA;
					end
				end
				TX_PARITY: begin
					line  <= 1'b1;
					state <= TX_STOP;
				end
				default: begin
					tx_busy <= 1'b0;
					state   <= TX_IDLE;
				end
			endcase
		end
	end

endmodule

//--- design/hsi_slave.sv
module hsi_slave import umio_pkg::*; #(
	parameter int BIT_DIV = 8
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  dat1,
	input  logic  dat2,
	input  logic  dat_sel,
	output word_t rx_word,
	output logic  rx_valid,
	output logic  rx_err
);

	localparam int CNT_W = $clog2(BIT_DIV);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BIT_DIV - 1);
	// Counter starts one cycle after the edge is seen
	localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(BIT_DIV / 2 - 1);
	localparam logic [4:0] LAST_DATA_SLOT = 5'(FRAME_BITS - 3);

	rx_state_t        state;
	logic [CNT_W-1:0] cnt;
	logic [4:0]       slot;
	word_t            shreg;
	logic             parity;
	logic             par_err;
	logic             sync1;
	logic             sync2;
	logic             line_d;
	logic             fall;
	logic             sample;

	assign fall   = line_d & ~sync2;
	assign sample = (cnt == CNT_MID);

	// Selected line through two flops and one more for the edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync1  <= 1'b1;
			sync2  <= 1'b1;
			line_d <= 1'b1;
		end else begin
			sync1  <= dat_sel ? dat2 : dat1;
			sync2  <= sync1;
			line_d <= sync2;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= RX_IDLE;
			cnt      <= '0;
			slot     <= '0;
			parity   <= 1'b1;
			par_err  <= 1'b0;
			rx_valid <= 1'b0;
			rx_err   <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			rx_err   <= 1'b0;
			cnt      <= (cnt == CNT_LAST) ? '0 : cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					if (fall) begin
						cnt   <= '0;
						state <= RX_START;
					end
				end
				RX_START: begin
					// A high line mid start bit is a glitch
					if (sample) begin
						slot   <= 5'd1;
						parity <= 1'b1;
						state  <= sync2 ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (sample) begin
						shreg  <= {shreg[14:0], sync2};
						parity <= parity ^ sync2;
						slot   <= slot + 1'b1;
						if (slot == LAST_DATA_SLOT) begin
							state <= RX_PARITY;
						end
					end
				end
				RX_PARITY: begin
					if (sample) begin
						par_err <= (sync2 != parity);
						state   <= RX_STOP;
					end
				end
				default: begin
					if (sample) begin
						if (sync2 && !par_err) begin
							rx_valid <= 1'b1;
						end else begin
							rx_err <= 1'b1;
						end
						state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// Word register loads with the stop sample
	always_ff @(posedge clk) begin
		if (state == RX_STOP && sample) begin
			rx_word <= shreg;
		end
	end

endmodule

//--- design/umio_base.sv
module umio_base import umio_pkg::*; #(
	parameter int BIT_DIV = 8
) (
	input  logic  clk,
	input  logic  rst_n,
	input  byte_t usb_d,
	input  logic  usb_valid,
	input  logic  dat1,
	input  logic  dat2,
	output logic  com1,
	output logic  com2,
	output word_t rx_word,
	output logic  rx_valid,
	output logic  rx_err
);

	reg_addr_t wr_addr;
	word_t     wr_data;
	logic      wr_en;

	logic  com1_en;
	logic  com2_en;
	logic  dat_sel;
	word_t tx_word;
	logic  tx_start;
	logic  tx_busy;

	// Host byte stream into register writes
	usb_decoder usb_dc (
		.clk       (clk),
		.rst_n     (rst_n),
		.usb_d     (usb_d),
		.usb_valid (usb_valid),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.wr_en     (wr_en)
	);

	usb_ctrl_regs usb_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_en    (wr_en),
		.tx_busy  (tx_busy),
		.com1_en  (com1_en),
		.com2_en  (com2_en),
		.dat_sel  (dat_sel),
		.tx_word  (tx_word),
		.tx_start (tx_start)
	);

	// Command lines out
	hsi_master #(
		.BIT_DIV (BIT_DIV)
	) hsi_mstr (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_word  (tx_word),
		.tx_start (tx_start),
		.com1_en  (com1_en),
		.com2_en  (com2_en),
		.com1     (com1),
		.com2     (com2),
		.tx_busy  (tx_busy)
	);

	// Data lines in
	hsi_slave #(
		.BIT_DIV (BIT_DIV)
	) hsi_slv (
		.clk      (clk),
		.rst_n    (rst_n),
		.dat1     (dat1),
		.dat2     (dat2),
		.dat_sel  (dat_sel),
		.rx_word  (rx_word),
		.rx_valid (rx_valid),
		.rx_err   (rx_err)
	);

endmodule

//--- testbench/umio_checker.sv
module umio_checker import umio_pkg::*; #(
	parameter int BIT_DIV = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       com1,
	input  logic       com2,
	input  word_t      rx_word,
	input  logic       rx_valid,
	input  logic       rx_err,
	input  logic       test_begin,
	input  logic       test_end,
	input  byte_t      test_code,
	input  word_t      exp_word,
	input  logic [1:0] exp_lines,
	input  logic [1:0] exp_rx,
	output int         n_tests,
	output int         n_failed
);

	logic [1:0]  com;
	logic        busy [2];
	logic        fmt_bad [2];
	logic [18:0] frm [2];
	int          pos [2];
	int          nbits [2];
	int          frames [2];
	int          lows [2];
	word_t       got_word [2];
	word_t       got_rx;
	int          n_valid;
	int          n_err;

	assign com = {com2, com1};

	// Test window compared against the driver's expectations
	task automatic check_test();
		int errs;
		errs = 0;
		n_tests++;
		for (int i = 0; i < 2; i++) begin
			if (exp_lines[i]) begin
				if (frames[i] != 1) begin
					$display("** Error test %0d: com%0d frames got %0h exp 1",
						n_tests, i + 1, frames[i]);
					errs++;
				end else if (got_word[i] != exp_word) begin
					$display("** Error test %0d: com%0d word got %h exp %h",
						n_tests, i + 1, got_word[i], exp_word);
					errs++;
				end
				if (fmt_bad[i]) begin
					$display("Test %0d: com%0d frame had a bad start, parity or stop bit",
						n_tests, i + 1);
					errs++;
				end
			end else if (lows[i] != 0) begin
				$display("** Error test %0d: com%0d got 0 exp 1 (%0d cycles)",
					n_tests, i + 1, lows[i]);
				errs++;
			end
			if (busy[i]) begin
				$display("Test %0d: com%0d frame still in progress at the end of the window",
					n_tests, i + 1);
				errs++;
			end
		end
		if (n_valid != int'(exp_rx == 2'd1)) begin
			$display("** Error test %0d: rx_valid count got %0h exp %0h",
				n_tests, n_valid, int'(exp_rx == 2'd1));
			errs++;
		end else if (exp_rx == 2'd1 && got_rx != exp_word) begin
			$display("** Error test %0d: rx_word got %h exp %h", n_tests, got_rx, exp_word);
			errs++;
		end
		if (n_err != int'(exp_rx == 2'd2)) begin
			$display("** Error test %0d: rx_err count got %0h exp %0h",
				n_tests, n_err, int'(exp_rx == 2'd2));
			errs++;
		end
		if (errs != 0) begin
			n_failed++;
			$display("Test %0d (%c) failed with %0d errors", n_tests, test_code, errs);
		end else begin
			$display("Test %0d (%c) passed", n_tests, test_code);
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			n_tests  = 0;
			n_failed = 0;
			busy[0]  = 1'b0;
			busy[1]  = 1'b0;
		end else begin
			if (test_begin) begin
				n_valid = 0;
				n_err   = 0;
				for (int i = 0; i < 2; i++) begin
					frames[i]  = 0;
					lows[i]    = 0;
					fmt_bad[i] = 1'b0;
				end
			end
			// Each command line decoded on its own and sampled mid bit
			for (int i = 0; i < 2; i++) begin
				if (!com[i]) begin
					lows[i]++;
				end
				if (!busy[i] && !com[i]) begin
					busy[i]  = 1'b1;
					pos[i]   = 1;
					nbits[i] = 0;
				end else if (busy[i]) begin
					if (pos[i] % BIT_DIV == BIT_DIV / 2) begin
						frm[i] = {frm[i][17:0], com[i]};
						nbits[i]++;
					end
					pos[i]++;
					if (nbits[i] == FRAME_BITS) begin
						busy[i]     = 1'b0;
						frames[i]++;
						got_word[i] = frm[i][17:2];
						// Start low, stop high, odd count of ones over data and parity
						if (frm[i][18] || !frm[i][0] || !(^frm[i][17:1])) begin
							fmt_bad[i] = 1'b1;
						end
					end
				end
			end
			if (rx_valid) begin
				n_valid++;
				got_rx = rx_word;
			end
			if (rx_err) begin
				n_err++;
			end
			if (test_end) begin
				check_test();
			end
		end
	end

endmodule

//--- testbench/tb_umio_base.sv
module tb_umio_base import umio_pkg::*; ();

	localparam int BIT_DIV = 8;
	// Up to 25 bit periods per test, doubled to cover the stimulus
	localparam int TEST_CYCLES = 2 * 25 * BIT_DIV;

	logic        clk;
	logic        rst_n;
	byte_t       usb_d;
	logic        usb_valid;
	logic        dat1;
	logic        dat2;
	logic        com1;
	logic        com2;
	word_t       rx_word;
	logic        rx_valid;
	logic        rx_err;
	logic        test_begin;
	logic        test_end;
	byte_t       test_code;
	word_t       exp_word;
	logic [1:0]  exp_lines;
	logic [1:0]  exp_rx;
	int          n_tests;
	int          n_failed;
	int          limit;
	int          seed;
	logic        bad_code;
	logic [2:0]  ctrl;
	byte_t       codes [$];
	logic [31:0] arg_a [$];
	logic [31:0] arg_b [$];
	logic [31:0] arg_c [$];

	always #4 clk = ~clk;

	umio_base #(.BIT_DIV (BIT_DIV)) dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.usb_d     (usb_d),
		.usb_valid (usb_valid),
		.dat1      (dat1),
		.dat2      (dat2),
		.com1      (com1),
		.com2      (com2),
		.rx_word   (rx_word),
		.rx_valid  (rx_valid),
		.rx_err    (rx_err)
	);

	umio_checker #(.BIT_DIV (BIT_DIV)) chk0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.com1       (com1),
		.com2       (com2),
		.rx_word    (rx_word),
		.rx_valid   (rx_valid),
		.rx_err     (rx_err),
		.test_begin (test_begin),
		.test_end   (test_end),
		.test_code  (test_code),
		.exp_word   (exp_word),
		.exp_lines  (exp_lines),
		.exp_rx     (exp_rx),
		.n_tests    (n_tests),
		.n_failed   (n_failed)
	);

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic send_byte(input byte_t b);
		usb_d     <= b;
		usb_valid <= 1'b1;
		@(posedge clk);
		usb_valid <= 1'b0;
	endtask

	// Host frame is sync, address, data high, data low
	task automatic write_reg(input reg_addr_t addr, input word_t data);
		send_byte(SYNC_BYTE);
		send_byte(addr);
		send_byte(data[15:8]);
		send_byte(data[7:0]);
	endtask

	task automatic drive_frame(input logic to_dat2, input word_t w, input logic corrupt);
		logic        par;
		logic [18:0] bits;
		par  = ~^w;
		par  = corrupt ? ~par : par;
		bits = {1'b0, w, par, 1'b1};
		for (int i = 18; i >= 0; i--) begin
			if (to_dat2) begin
				dat2 <= bits[i];
			end else begin
				dat1 <= bits[i];
			end
			wait_cycles(BIT_DIV);
		end
	endtask

	task automatic begin_test(input byte_t code, input word_t w, input logic [1:0] lines,
			input logic [1:0] rx);
		test_code  <= code;
		exp_word   <= w;
		exp_lines  <= lines;
		exp_rx     <= rx;
		test_begin <= 1'b1;
		@(posedge clk);
		test_begin <= 1'b0;
	endtask

	task automatic end_test();
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	task automatic read_tests(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen("testbench/umio_tests.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line[0] != "#") begin
					a = '0;
					b = '0;
					c = '0;
					void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
					codes.push_back(line[0]);
					arg_a.push_back(a);
					arg_b.push_back(b);
					arg_c.push_back(c);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_one(input byte_t code, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] c);
		logic [1:0] lines;
		logic [1:0] rx;
		logic [1:0] sel_line;
		int         rnd;
		byte_t      jb;
		// Expectations follow from the control bits written so far
		lines    = (code == "T") ? ctrl[1:0] : 2'b00;
		sel_line = ctrl[2] ? 2'd2 : 2'd1;
		rx       = 2'b00;
		if (code == "R" && b[1:0] == sel_line) begin
			rx = (c != 0) ? 2'd2 : 2'd1;
		end
		begin_test(code, a[15:0], lines, rx);
		case (code)
			"J": begin
				repeat (a) begin
					rnd = $random(seed);
					// A sync byte in the junk would open a frame
					jb  = (rnd[7:0] == SYNC_BYTE) ? 8'h00 : rnd[7:0];
					send_byte(jb);
				end
				wait_cycles(4 * BIT_DIV);
			end
			"C": begin
				write_reg(ADDR_CTRL, a[15:0]);
				ctrl = a[2:0];
				wait_cycles(4 * BIT_DIV);
			end
			"T": begin
				write_reg(ADDR_TX, a[15:0]);
				if (b != 0) begin
					// Second request lands mid frame
					wait_cycles(5 * BIT_DIV);
					write_reg(ADDR_TX, c[15:0]);
				end
				wait_cycles(25 * BIT_DIV);
			end
			"R": begin
				drive_frame(b[1:0] == 2'd2, a[15:0], c != 0);
				wait_cycles(25 * BIT_DIV);
			end
			default: begin
				$display("Unknown test code %c in the vector file", code);
				bad_code = 1'b1;
			end
		endcase
		end_test();
	endtask

	initial begin
		bit ok;
		clk        = 1'b0;
		rst_n      = 1'b0;
		usb_d      = '0;
		usb_valid  = 1'b0;
		dat1       = 1'b1;
		dat2       = 1'b1;
		test_begin = 1'b0;
		test_end   = 1'b0;
		test_code  = "I";
		exp_word   = '0;
		exp_lines  = 2'b00;
		exp_rx     = 2'b00;
		ctrl       = 3'b011;
		seed       = 32'h809b;
		bad_code   = 1'b0;
		limit      = 0;
		read_tests(ok);
		if (!ok || codes.size() == 0) begin
			$display("Could not read any tests from testbench/umio_tests.txt");
			$display("Simulation FAILED");
			$finish;
		end else begin
			limit = (codes.size() + 1) * TEST_CYCLES;
			repeat (2) @(posedge clk);
			rst_n <= 1'b1;
			@(posedge clk);
			// Idle lines and no strobes straight out of reset
			begin_test("I", '0, 2'b00, 2'b00);
			wait_cycles(10 * BIT_DIV);
			end_test();
			foreach (codes[k]) begin
				run_one(codes[k], arg_a[k], arg_b[k], arg_c[k]);
			end
			@(posedge clk);
			$display("Tests run %0d, failed %0d", n_tests, n_failed);
			if (n_failed == 0 && !bad_code) begin
				$display("Simulation PASSED");
			end else begin
				$display("Simulation FAILED");
			end
			$finish;
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		wait (limit != 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run did not finish within %0d cycles", limit);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- testbench/umio_tests.txt
# code arg1 arg2 arg3, all hex
# J junk count | C ctrl value | T word, second write flag, second word | R word, line, corrupt
J 6 0 0
T 1234 0 0
T 8001 0 0
C 1 0 0
T BEEF 0 0
C 2 0 0
T 00FF 0 0
C 3 0 0
T CAFE 1 5555
J 3 0 0
T 0000 0 0
R A55A 1 0
R FFFF 1 1
R 0F0F 2 0
C 7 0 0
R 1357 2 0
R 2468 2 1
R 9ABC 1 0
T 7E81 0 0
C 3 0 0
T FFFF 0 0

//--- umio_base.f
design/umio_pkg.sv
design/usb_decoder.sv
design/usb_ctrl_regs.sv
design/hsi_master.sv
design/hsi_slave.sv
design/umio_base.sv
testbench/umio_checker.sv
testbench/tb_umio_base.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_umio_base -f umio_base.f -o sim_umio
output=$(./obj_dir/sim_umio)
echo "$output"

if grep -qx "Simulation PASSED" <<< "$output"; then
	exit 0
else
	exit 1
fi
